//--- capture/capture_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module capture_ctrl #(
   parameter int WIN_W = frame_grab_pkg::DEF_WIN_W,
   parameter int WIN_H = frame_grab_pkg::DEF_WIN_H
) (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     live,
   input  frame_grab_pkg::rgb24_t   pixel_in,
   video_timing_if.sink             tim,
   output frame_grab_pkg::addr_t    addr,
   output logic                     we,
   output frame_grab_pkg::rgb332_t  wdata,
   output frame_grab_pkg::pix_src_t src
);
   import frame_grab_pkg::*;

   // last store address of one window
   localparam addr_t LAST_ADDR = addr_t'(WIN_W * WIN_H - 1);
   localparam hcount_t WIN_X = hcount_t'(WIN_W);
   localparam vcount_t WIN_Y = vcount_t'(WIN_H);

   logic     live_meta;
   logic     live_sync;
   logic     live_prev;
   logic     live_fall;
   logic     live_rise;
   logic     frozen;
   logic     capturing;
   logic     loaded;
   logic     in_win;
   logic     at_origin;
   logic     cap_pixel;
   addr_t    wr_cnt;
   addr_t    rd_cnt;
   pix_src_t src_next;

   ////////////////////////////////////////
   // position decode
   ////////////////////////////////////////

   assign in_win = (tim.hcount < WIN_X) && (tim.vcount < WIN_Y);
   assign at_origin = (tim.hcount == '0) && (tim.vcount == '0);

   // mode edges after the synchronizer
   assign live_fall = live_prev && !live_sync;
   assign live_rise = !live_prev && live_sync;

   // origin pixel is written in the same cycle capture starts
   assign cap_pixel = frozen && !loaded && in_win && (capturing || at_origin);

   // writes use the write counter until the window is full
   assign addr = loaded ? rd_cnt : wr_cnt;

   // black while live or while the window fills, white around it
   always_comb begin
      if (!frozen) begin
         src_next = SRC_BLACK;
      end else if (in_win) begin
         src_next = loaded ? SRC_STORED : SRC_BLACK;
      end else begin
         src_next = SRC_WHITE;
      end
   end

   ////////////////////////////////////////
   // mode, capture and replay state
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         live_meta <= 1'b0;
         live_sync <= 1'b0;
         live_prev <= 1'b0;
         frozen <= 1'b0;
         capturing <= 1'b0;
         loaded <= 1'b0;
         wr_cnt <= '0;
         rd_cnt <= '0;
         we <= 1'b0;
         src <= SRC_BLACK;
      end else begin
         live_meta <= live;
         live_sync <= live_meta;
         live_prev <= live_sync;
         // write strobe lines up with the combinational address
         we <= cap_pixel;
         src <= src_next;
         if (live_rise) begin
            // back to live video
            frozen <= 1'b0;
            capturing <= 1'b0;
            loaded <= 1'b0;
         end else if (live_fall) begin
            // arm, capture begins at the next frame origin
            frozen <= 1'b1;
            wr_cnt <= '0;
            rd_cnt <= '0;
         end else begin
            if (frozen && !loaded && at_origin) begin
               capturing <= 1'b1;
            end
            // counter moves once the write lands
            if (we) begin
               wr_cnt <= wr_cnt + addr_t'(1);
               if (wr_cnt == LAST_ADDR) begin
                  loaded <= 1'b1;
                  capturing <= 1'b0;
               end
            end
            // replay walks the window once per frame
            if (loaded && in_win) begin
               rd_cnt <= (rd_cnt == LAST_ADDR) ? '0 : rd_cnt + addr_t'(1);
            end
         end
      end
   end

   // reduce to 3-3-2 by keeping the top bits of each channel
   always_ff @(posedge clk) begin
      wdata <= '{red: pixel_in.red[7:5], green: pixel_in.green[7:5], blue: pixel_in.blue[7:6]};
   end

endmodule

`default_nettype wire

//--- capture/frame_store.sv
`timescale 1ns/1ns
`default_nettype none

module frame_store #(
   parameter int DEPTH = frame_grab_pkg::DEF_WIN_W * frame_grab_pkg::DEF_WIN_H
) (
   input  logic                    clk,
   input  frame_grab_pkg::addr_t   addr,
   input  logic                    we,
   input  frame_grab_pkg::rgb332_t wdata,
   output frame_grab_pkg::rgb332_t rdata
);
   import frame_grab_pkg::*;

   // address bits needed to reach every entry of the window
   localparam int IDX_W = $clog2(DEPTH);

   logic [IDX_W-1:0] idx;

   ////////////////////////////////////////
   // one captured window in raster order
   ////////////////////////////////////////

   // maps onto a single port block RAM
   rgb332_t mem [DEPTH];

   assign idx = addr[IDX_W-1:0];

   // write when strobed and read data one clock after the address
   always_ff @(posedge clk) begin
      if (we) begin
         mem[idx] <= wdata;
      end
      rdata <= mem[idx];
   end

endmodule

`default_nettype wire

//--- common/frame_grab_pkg.sv
`default_nettype none

package frame_grab_pkg;

   ////////////////////////////////////////
   // widths
   ////////////////////////////////////////

   // pixel count across the full line, porches included
   localparam int HCOUNT_W = 11;
   // line count across the full frame
   localparam int VCOUNT_W = 10;
   // frame store address, enough for a 640x400 window
   localparam int ADDR_W = 18;

   ////////////////////////////////////////
   // default 1024x768 raster
   ////////////////////////////////////////

   // horizontal, 1344 clocks per line
   localparam int DEF_H_ACTIVE = 1024;
   localparam int DEF_H_FRONT = 24;
   localparam int DEF_H_SYNC = 136;
   localparam int DEF_H_BACK = 160;

   // vertical, 806 lines per frame
   localparam int DEF_V_ACTIVE = 768;
   localparam int DEF_V_FRONT = 9;
   localparam int DEF_V_SYNC = 6;
   localparam int DEF_V_BACK = 23;

   // capture window, anchored at the frame origin
   localparam int DEF_WIN_W = 640;
   localparam int DEF_WIN_H = 400;

   typedef logic [HCOUNT_W-1:0] hcount_t;
   typedef logic [VCOUNT_W-1:0] vcount_t;
   typedef logic [ADDR_W-1:0] addr_t;

   // full colour pixel as it enters and leaves
   typedef struct packed {
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
   } rgb24_t;

   // reduced pixel as it sits in the frame store
   typedef struct packed {
      logic [2:0] red;
      logic [2:0] green;
      logic [1:0] blue;
   } rgb332_t;

   // what the output stage shows for one position
   typedef enum logic [1:0] {
      SRC_BLACK  = 2'd0,
      SRC_WHITE  = 2'd1,
      SRC_STORED = 2'd2
   } pix_src_t;

endpackage

`default_nettype wire

//--- common/video_timing_if.sv
`timescale 1ns/1ns
`default_nettype none

interface video_timing_if;
   import frame_grab_pkg::*;

   // raster position, advances once per clock
   hcount_t hcount;
   vcount_t vcount;
   // active low syncs
   logic hsync;
   logic vsync;
   // high outside the active area
   logic blank;

   // driven by the timing generator
   modport source (output hcount, vcount, hsync, vsync, blank);

   // read by capture and output stages
   modport sink (input hcount, vcount, hsync, vsync, blank);

endinterface

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# compile the frame grabber testbench with Verilator and run it
# the result is taken from the simulation output

cd "$(dirname "$0")" || exit 1

sim_out=""
verilator --binary --timing -f vlog.f --top-module frame_grab_tb \
   && sim_out="$(./obj_dir/Vframe_grab_tb)" \
   || echo "build or simulation did not complete"

printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qx "Test passed" \
   && echo "simulation result: pass" \
   || { echo "simulation result: fail"; exit 1; }

//--- tb/frame_grab_tb.sv
`timescale 1ns/1ns
`default_nettype none

module frame_grab_tb;
   import frame_grab_pkg::*;

   ////////////////////////////////////////
   // small raster, 24x12 clocks per frame
   ////////////////////////////////////////

   localparam int H_ACTIVE = 16;
   localparam int H_FRONT = 2;
   localparam int H_SYNC = 3;
   localparam int H_BACK = 3;
   localparam int V_ACTIVE = 8;
   localparam int V_FRONT = 1;
   localparam int V_SYNC = 2;
   localparam int V_BACK = 1;
   localparam int WIN_W = 12;
   localparam int WIN_H = 6;
   localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
   localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
   localparam int FRAME_LEN = H_TOTAL * V_TOTAL;
   localparam int FRAMES = 10;
   localparam int TOTAL = FRAMES * FRAME_LEN;
   localparam int CLK_PERIOD = 40;
   localparam int RESET_CYCLES = 3;
   // two synchronizer flops plus the edge register
   localparam int SYNC_LAT = 3;
   // live toggles at the start of line 10, inside vertical blank
   localparam int TOGGLE_Q = 10 * H_TOTAL;
   localparam int FREEZE_1 = 2 * FRAME_LEN + TOGGLE_Q;
   localparam int RISE_1 = 5 * FRAME_LEN + TOGGLE_Q;
   localparam int FREEZE_2 = 6 * FRAME_LEN + TOGGLE_Q;
   localparam int NUM_TESTS = 6;
   localparam int WATCHDOG_NS = (TOTAL + RESET_CYCLES + 64) * CLK_PERIOD;

   logic       clk;
   logic       arst_n;
   logic       live;
   rgb24_t     pixel_in;
   logic [7:0] vga_red;
   logic [7:0] vga_green;
   logic [7:0] vga_blue;
   logic       vga_hsync;
   logic       vga_vsync;
   logic       vga_blank_n;

   // position shown by the timing generator in the current cycle
   int          pos_idx;
   integer      seed;
   logic [23:0] pix_hist [TOTAL + 8];
   bit          live_hist [TOTAL + 8];
   int          err_cnt [NUM_TESTS];
   int          chk_cnt [NUM_TESTS];

   frame_grab_top #(
      .H_ACTIVE (H_ACTIVE),
      .H_FRONT  (H_FRONT),
      .H_SYNC   (H_SYNC),
      .H_BACK   (H_BACK),
      .V_ACTIVE (V_ACTIVE),
      .V_FRONT  (V_FRONT),
      .V_SYNC   (V_SYNC),
      .V_BACK   (V_BACK),
      .WIN_W    (WIN_W),
      .WIN_H    (WIN_H)
   ) dut (
      .clk         (clk),
      .arst_n      (arst_n),
      .live        (live),
      .pixel_in    (pixel_in),
      .vga_red     (vga_red),
      .vga_green   (vga_green),
      .vga_blue    (vga_blue),
      .vga_hsync   (vga_hsync),
      .vga_vsync   (vga_vsync),
      .vga_blank_n (vga_blank_n)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////

   // mode input level planned for each position
   function automatic bit live_level(input int n);
      return !(((n >= FREEZE_1) && (n < RISE_1)) || (n >= FREEZE_2));
   endfunction

   // frames grouped into the checked behaviours
   function automatic int test_of_frame(input int frame);
      if (frame < 2) return 1;
      if (frame == 2) return 2;
      if (frame == 3) return 3;
      if (frame < 6) return 4;
      return 5;
   endfunction

   function automatic string name_of_test(input int t);
      case (t)
         0: return "reset state";
         1: return "sync and blank timing";
         2: return "live output black";
         3: return "capture frame";
         4: return "replay of stored frame";
         5: return "back to live and recapture";
         default: return "unknown";
      endcase
   endfunction

   // expected {colour, hsync, vsync, blank_n} for one position
   function automatic logic [26:0] expected_out(input int h, input int v, input bit frozen,
                                                input bit replay, input logic [23:0] cap_pix);
      logic [23:0] colour;
      logic        hs;
      logic        vs;
      logic        bn;
      bit          in_win;
      in_win = (h < WIN_W) && (v < WIN_H);
      hs = !((h >= H_ACTIVE + H_FRONT) && (h < H_ACTIVE + H_FRONT + H_SYNC));
      vs = !((v >= V_ACTIVE + V_FRONT) && (v < V_ACTIVE + V_FRONT + V_SYNC));
      bn = !((h >= H_ACTIVE) || (v >= V_ACTIVE));
      // colour is not forced under blank, blank_n alone gates the DAC
      if (!frozen) begin
         colour = 24'h000000;
      end else if (!in_win) begin
         colour = 24'hffffff;
      end else if (!replay) begin
         colour = 24'h000000;
      end else begin
         // 3-3-2 reduction, then zero fill of the dropped bits
         colour = {cap_pix[23:21], 5'd0, cap_pix[15:13], 5'd0, cap_pix[7:6], 6'd0};
      end
      return {colour, hs, vs, bn};
   endfunction

   task automatic check_field(input string what, input int idx, input int h, input int v,
                              input logic [23:0] got, input logic [23:0] exp, input int t);
      chk_cnt[t] = chk_cnt[t] + 1;
      if (got !== exp) begin
         err_cnt[t] = err_cnt[t] + 1;
         $display("[ERROR] %0t ns: %s at pos %0d (h %0d, v %0d) got %h expected %h",
                  $time, what, idx, h, v, got, exp);
      end
   endtask

   task automatic report_test(input int t);
      if (err_cnt[t] == 0) begin
         $display("test %0d %s: %0d checks ok", t + 1, name_of_test(t), chk_cnt[t]);
      end else begin
         $display("test %0d %s: %0d checks, %0d mismatches", t + 1, name_of_test(t),
                  chk_cnt[t], err_cnt[t]);
      end
   endtask

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////

   initial begin : drive_inputs
      int          f;
      int          rnd;
      logic [23:0] pix;
      arst_n = 1'b0;
      live = 1'b1;
      pixel_in = '0;
      pos_idx = -5;
      seed = 32'h44a8739d;
      repeat (RESET_CYCLES - 1) @(posedge clk);
      for (int n = 0; n < TOTAL + 4; n++) begin
         @(posedge clk);
         if (n == 0) begin
            arst_n <= 1'b1;
         end
         pos_idx = n;
         f = n / FRAME_LEN;
         rnd = $random(seed);
         // random value mixed with frame number and position
         pix = rnd[23:0] ^ {8'(f), 16'(n % FRAME_LEN)};
         pix_hist[n] = pix;
         live_hist[n] = live_level(n);
         pixel_in <= rgb24_t'(pix);
         live <= live_level(n);
      end
   end

   ////////////////////////////////////////
   // output comparison, once per cycle
   ////////////////////////////////////////

   initial begin : compare_outputs
      int          idx;
      int          frame;
      int          q;
      int          h;
      int          v;
      int          t;
      int          prev_t;
      int          cap_f;
      int          total_chk;
      int          total_err;
      bit          frozen;
      bit          replay;
      bit          cap_valid;
      bit          finished;
      logic [23:0] cap_pix;
      logic [26:0] exp;
      prev_t = 0;
      cap_f = 0;
      cap_valid = 1'b0;
      replay = 1'b0;
      finished = 1'b0;
      for (int i = 0; i < NUM_TESTS; i++) begin
         err_cnt[i] = 0;
         chk_cnt[i] = 0;
      end
      while (!finished) begin
         @(negedge clk);
         // outputs trail the raster position by two clocks
         idx = pos_idx - 2;
         h = 0;
         v = 0;
         if (idx < 0) begin
            t = 0;
            exp = {24'h000000, 3'b111};
         end else begin
            frame = idx / FRAME_LEN;
            q = idx % FRAME_LEN;
            h = q % H_TOTAL;
            v = q / H_TOTAL;
            frozen = 1'b0;
            if (idx >= SYNC_LAT) begin
               frozen = !live_hist[idx - SYNC_LAT];
            end
            // first frozen origin starts the capture, later ones replay it
            if (!frozen) begin
               cap_valid = 1'b0;
               replay = 1'b0;
            end else if (q == 0) begin
               if (cap_valid) begin
                  replay = 1'b1;
               end else begin
                  cap_valid = 1'b1;
                  cap_f = frame;
                  replay = 1'b0;
               end
            end
            cap_pix = pix_hist[cap_f * FRAME_LEN + q];
            exp = expected_out(h, v, frozen, replay, cap_pix);
            t = test_of_frame(frame);
         end
         if (t != prev_t) begin
            report_test(prev_t);
            prev_t = t;
         end
         check_field("colour", idx, h, v, {vga_red, vga_green, vga_blue}, exp[26:3], t);
         check_field("hsync", idx, h, v, {23'd0, vga_hsync}, {23'd0, exp[2]}, t);
         check_field("vsync", idx, h, v, {23'd0, vga_vsync}, {23'd0, exp[1]}, t);
         check_field("blank_n", idx, h, v, {23'd0, vga_blank_n}, {23'd0, exp[0]}, t);
         if (idx == TOTAL - 1) begin
            finished = 1'b1;
         end
      end
      report_test(prev_t);
      total_chk = 0;
      total_err = 0;
      for (int i = 0; i < NUM_TESTS; i++) begin
         total_chk = total_chk + chk_cnt[i];
         total_err = total_err + err_cnt[i];
      end
      $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, total_chk, total_err);
      if (total_err == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // ends a run whose comparison never reaches the last frame
   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("timeout: output comparison did not finish within %0d ns", WATCHDOG_NS);
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/frame_grab_top.sv
`timescale 1ns/1ns
`default_nettype none

module frame_grab_top #(
   parameter int H_ACTIVE = frame_grab_pkg::DEF_H_ACTIVE,
   parameter int H_FRONT = frame_grab_pkg::DEF_H_FRONT,
   parameter int H_SYNC = frame_grab_pkg::DEF_H_SYNC,
   parameter int H_BACK = frame_grab_pkg::DEF_H_BACK,
   parameter int V_ACTIVE = frame_grab_pkg::DEF_V_ACTIVE,
   parameter int V_FRONT = frame_grab_pkg::DEF_V_FRONT,
   parameter int V_SYNC = frame_grab_pkg::DEF_V_SYNC,
   parameter int V_BACK = frame_grab_pkg::DEF_V_BACK,
   parameter int WIN_W = frame_grab_pkg::DEF_WIN_W,
   parameter int WIN_H = frame_grab_pkg::DEF_WIN_H
) (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   live,
   input  frame_grab_pkg::rgb24_t pixel_in,
   output logic [7:0]             vga_red,
   output logic [7:0]             vga_green,
   output logic [7:0]             vga_blue,
   output logic                   vga_hsync,
   output logic                   vga_vsync,
   output logic                   vga_blank_n
);
   import frame_grab_pkg::*;

   addr_t    addr;
   logic     we;
   rgb332_t  wdata;
   rgb332_t  rdata;
   pix_src_t src;

   // shared raster position
   video_timing_if tim ();

   video_timing #(
      .H_ACTIVE (H_ACTIVE),
      .H_FRONT  (H_FRONT),
      .H_SYNC   (H_SYNC),
      .H_BACK   (H_BACK),
      .V_ACTIVE (V_ACTIVE),
      .V_FRONT  (V_FRONT),
      .V_SYNC   (V_SYNC),
      .V_BACK   (V_BACK)
   ) u_timing (
      .clk    (clk),
      .arst_n (arst_n),
      .tim    (tim.source)
   );

   capture_ctrl #(
      .WIN_W (WIN_W),
      .WIN_H (WIN_H)
   ) u_capture (
      .clk      (clk),
      .arst_n   (arst_n),
      .live     (live),
      .pixel_in (pixel_in),
      .tim      (tim.sink),
      .addr     (addr),
      .we       (we),
      .wdata    (wdata),
      .src      (src)
   );

   // sized for exactly one window
   frame_store #(
      .DEPTH (WIN_W * WIN_H)
   ) u_store (
      .clk   (clk),
      .addr  (addr),
      .we    (we),
      .wdata (wdata),
      .rdata (rdata)
   );

   pixel_out u_out (
      .clk         (clk),
      .arst_n      (arst_n),
      .tim         (tim.sink),
      .src         (src),
      .rdata       (rdata),
      .vga_red     (vga_red),
      .vga_green   (vga_green),
      .vga_blue    (vga_blue),
      .vga_hsync   (vga_hsync),
      .vga_vsync   (vga_vsync),
      .vga_blank_n (vga_blank_n)
   );

endmodule

`default_nettype wire

//--- verilog/pixel_out.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_out (
   input  logic                     clk,
   input  logic                     arst_n,
   video_timing_if.sink             tim,
   input  frame_grab_pkg::pix_src_t src,
   input  frame_grab_pkg::rgb332_t  rdata,
   output logic [7:0]               vga_red,
   output logic [7:0]               vga_green,
   output logic [7:0]               vga_blue,
   output logic                     vga_hsync,
   output logic                     vga_vsync,
   output logic                     vga_blank_n
);
   import frame_grab_pkg::*;

   rgb24_t     pix_sel;
   logic [1:0] hs_pipe;
   logic [1:0] vs_pipe;
   logic [1:0] bn_pipe;

   ////////////////////////////////////////
   // colour select
   ////////////////////////////////////////

   // src and rdata both arrive one clock after the position
   always_comb begin
      case (src)
         SRC_WHITE: begin
            pix_sel = '{red: 8'hff, green: 8'hff, blue: 8'hff};
         end
         SRC_STORED: begin
            // zero fill below the stored bits
            pix_sel = '{red: {rdata.red, 5'd0}, green: {rdata.green, 5'd0},
                        blue: {rdata.blue, 6'd0}};
         end
         default: begin
            pix_sel = '0;
         end
      endcase
   end

   ////////////////////////////////////////
   // output registers
   ////////////////////////////////////////

   // colour is registered once, so it leaves two clocks after
   // the position; syncs and blank get two stages to match
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         vga_red <= '0;
         vga_green <= '0;
         vga_blue <= '0;
         hs_pipe <= '1;
         vs_pipe <= '1;
         bn_pipe <= '1;
      end else begin
         vga_red <= pix_sel.red;
         vga_green <= pix_sel.green;
         vga_blue <= pix_sel.blue;
         hs_pipe <= {hs_pipe[0], tim.hsync};
         vs_pipe <= {vs_pipe[0], tim.vsync};
         // DAC wants blank active low
         bn_pipe <= {bn_pipe[0], !tim.blank};
      end
   end

   assign vga_hsync = hs_pipe[1];
   assign vga_vsync = vs_pipe[1];
   assign vga_blank_n = bn_pipe[1];

endmodule

`default_nettype wire

//--- verilog/video_timing.sv
`timescale 1ns/1ns
`default_nettype none

module video_timing #(
   parameter int H_ACTIVE = frame_grab_pkg::DEF_H_ACTIVE,
   parameter int H_FRONT = frame_grab_pkg::DEF_H_FRONT,
   parameter int H_SYNC = frame_grab_pkg::DEF_H_SYNC,
   parameter int H_BACK = frame_grab_pkg::DEF_H_BACK,
   parameter int V_ACTIVE = frame_grab_pkg::DEF_V_ACTIVE,
   parameter int V_FRONT = frame_grab_pkg::DEF_V_FRONT,
   parameter int V_SYNC = frame_grab_pkg::DEF_V_SYNC,
   parameter int V_BACK = frame_grab_pkg::DEF_V_BACK
) (
   input  logic           clk,
   input  logic           arst_n,
   video_timing_if.source tim
);
   import frame_grab_pkg::*;

   ////////////////////////////////////////
   // raster limits
   ////////////////////////////////////////

   // last count before each counter wraps
   localparam hcount_t H_LAST = hcount_t'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
   localparam vcount_t V_LAST = vcount_t'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);

   // end of active area
   localparam hcount_t H_ACT_END = hcount_t'(H_ACTIVE);
   localparam vcount_t V_ACT_END = vcount_t'(V_ACTIVE);

   // sync pulse sits right after the front porch
   localparam hcount_t HS_START = hcount_t'(H_ACTIVE + H_FRONT);
   localparam hcount_t HS_END = hcount_t'(H_ACTIVE + H_FRONT + H_SYNC);
   localparam vcount_t VS_START = vcount_t'(V_ACTIVE + V_FRONT);
   localparam vcount_t VS_END = vcount_t'(V_ACTIVE + V_FRONT + V_SYNC);

   hcount_t h_next;
   vcount_t v_next;
   logic    h_wrap;

   // position for the next clock
   always_comb begin
      h_wrap = (tim.hcount == H_LAST);
      h_next = h_wrap ? '0 : tim.hcount + hcount_t'(1);
      // line count only moves at the end of a line
      if (h_wrap) begin
         v_next = (tim.vcount == V_LAST) ? '0 : tim.vcount + vcount_t'(1);
      end else begin
         v_next = tim.vcount;
      end
   end

   ////////////////////////////////////////
   // registered counts, syncs and blank
   ////////////////////////////////////////

   // syncs and blank decode the next position, so all five
   // signals describe the same raster point in the same cycle
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         tim.hcount <= '0;
         tim.vcount <= '0;
         tim.hsync <= 1'b1;
         tim.vsync <= 1'b1;
         tim.blank <= 1'b0;
      end else begin
         tim.hcount <= h_next;
         tim.vcount <= v_next;
         tim.hsync <= !((h_next >= HS_START) && (h_next < HS_END));
         tim.vsync <= !((v_next >= VS_START) && (v_next < VS_END));
         // blank covers both porches and both syncs
         tim.blank <= (h_next >= H_ACT_END) || (v_next >= V_ACT_END);
      end
   end

endmodule

`default_nettype wire

//--- vlog.f
common/frame_grab_pkg.sv
common/video_timing_if.sv
verilog/video_timing.sv
capture/capture_ctrl.sv
capture/frame_store.sv
verilog/pixel_out.sv
verilog/frame_grab_top.sv
tb/frame_grab_tb.sv
